/* Makefile */
SRCS := $(wildcard source/*.sv dv/*.sv)

.PHONY: run clean

obj_dir/Vfrontend_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module frontend_tb -f filelist.f -o Vfrontend_tb

run: obj_dir/Vfrontend_tb
	@out="$$(./obj_dir/Vfrontend_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

/* dv/frontend_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_assertions import frontend_pkg::*; (
	input wire logic             clk,
	input wire logic             arst_n,
	input wire logic             redirect_en,
	input wire logic             stall,
	input wire logic [dec_w-1:0] dec_inst0,
	input wire logic [dec_w-1:0] dec_inst1,
	input wire logic [dec_w-1:0] dec_inst2,
	input wire logic [dec_w-1:0] dec_inst3,
	input wire logic             loop_start
);

	logic any_valid;

	assign any_valid = dec_inst0[dec_w-1] | dec_inst1[dec_w-1] |
		dec_inst2[dec_w-1] | dec_inst3[dec_w-1];

	quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !any_valid && !loop_start)
		else $error("valid or loop_start set during reset");

	quiet_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |=> !any_valid && !loop_start)
		else $error("valid or loop_start set just after reset");

	// one-cycle strobe
	short_loop_start: assert property (@(posedge clk) disable iff (!arst_n)
		loop_start |=> !loop_start)
		else $error("loop_start held for two cycles");

	// old path drained by the flush and two refill stages
	no_old_path: assert property (@(posedge clk) disable iff (!arst_n)
		redirect_en |-> ##2 !any_valid ##1 !any_valid)
		else $error("old path slots decoded after redirect");

	stall_bubble: assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> !any_valid)
		else $error("valid slots decoded while stalled");

endmodule

bind frontend_top frontend_assertions u_assert (.*);

`default_nettype wire

/* dv/frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_tb import frontend_pkg::*; ();

	logic clk;
	logic arst_n;
	logic imem_we;
	logic [imem_aw-1:0] imem_addr;
	logic [group_w-1:0] imem_wdata;
	logic redirect_en;
	logic [pc_w-1:0] redirect_pc;
	logic stall;
	logic [dec_w-1:0] dec_o [slots];
	logic [pc_w-1:0] dec_pc;
	logic [1:0] lbd_state;
	logic loop_start;

	logic [31:0] rng;
	logic [31:0] fill;
	logic [group_w-1:0] mem_m [imem_groups];
	logic [1:0] cnt_m [1024];
	logic [15:0] exp_pc;
	logic [15:0] base;
	logic [15:0] nxt;
	logic [15:0] tpc;
	logic tk;
	logic [dec_w-1:0] exp_w [slots];
	logic [1:0] exp_lbd;
	logic exp_ls;
	logic shown;
	logic redir_q;
	logic [15:0] rpc_q;
	int loops;
	int groups;
	int chk_err;
	int other_err;
	int cycles;

	frontend_top uut (
		.clk         (clk),
		.arst_n      (arst_n),
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_wdata  (imem_wdata),
		.redirect_en (redirect_en),
		.redirect_pc (redirect_pc),
		.stall       (stall),
		.dec_inst0   (dec_o[0]),
		.dec_inst1   (dec_o[1]),
		.dec_inst2   (dec_o[2]),
		.dec_inst3   (dec_o[3]),
		.dec_pc      (dec_pc),
		.lbd_state   (lbd_state),
		.loop_start  (loop_start)
	);

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1103515245 + 32'd12345;
		return rng;
	endfunction

	// decoded word from the encoding rules
	function automatic logic [dec_w-1:0] expect_word(input logic [15:0] ins, input logic pt);
		logic [2:0] a;
		logic [2:0] b;
		logic [2:0] c;
		a = ins[11:9];
		b = ins[8:6];
		c = ins[5:3];
		case (ins[15:12])
			op_nop: expect_word = {4'b1000, 3'd0, 15'd0};
			op_add: expect_word = {4'b1000, 3'd1, a, b, c, 6'd0};
			op_sub: expect_word = {4'b1000, 3'd2, a, b, c, 6'd0};
			op_addi: expect_word = {4'b1001, 3'd1, a, b, 3'd0, ins[5:0]};
			op_ld: expect_word = {4'b1001, 3'd3, a, b, 3'd0, ins[5:0]};
			op_st: expect_word = {4'b1001, 3'd4, 3'd0, b, a, ins[5:0]};
			op_beq: expect_word = {2'b11, pt, 1'b1, 3'd5, 3'd0, b, a, ins[5:0]};
			default: expect_word = '0;
		endcase
	endfunction

	task automatic count_error(input string what);
		chk_err++;
		$display("** Error at %0t: %s", $time, what);
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// expected group at exp_pc
	always_comb begin
		logic [15:0] ins;
		logic v;
		logic b;
		base = {exp_pc[15:2], 2'b00};
		tk = 1'b0;
		tpc = '0;
		nxt = base + 16'd4;
		for (int i = 0; i < 4; i++) begin
			ins = mem_m[base[7:2]][16*i +: 16];
			v = (i >= int'(exp_pc[1:0])) && !tk;
			b = v && (ins[15:12] == op_beq) && ins[5];
			exp_w[i] = v ? expect_word(ins, b) : '0;
			if (b) begin
				tk = 1'b1;
				tpc = base + 16'(i);
				nxt = tpc + 16'd1 + {{10{ins[5]}}, ins[5:0]};
			end
		end
		exp_lbd = '0;
		exp_ls = 1'b0;
		if (tk) begin
			exp_lbd = (cnt_m[tpc[9:0]] == 2'd3) ? 2'd3 : cnt_m[tpc[9:0]] + 2'd1;
			exp_ls = (cnt_m[tpc[9:0]] == 2'd2);
		end
	end

	assign shown = dec_o[0][dec_w-1] | dec_o[1][dec_w-1] | dec_o[2][dec_w-1] |
		dec_o[3][dec_w-1];

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exp_pc <= '0;
			redir_q <= 1'b0;
			rpc_q <= '0;
		end else begin
			redir_q <= redirect_en;
			rpc_q <= redirect_pc;
			if (shown) begin
				groups <= groups + 1;
				exp_pc <= nxt;
				if (tk) begin
					cnt_m[tpc[9:0]] <= exp_lbd;
					loops <= loops + 1;
				end
			end
			// group after the redirect edge was the last one of the old path
			if (redir_q) begin
				exp_pc <= rpc_q;
			end
		end
	end

	for (genvar g = 0; g < 4; g++) begin : g_chk
		slot_ok: assert property (@(posedge clk) disable iff (!arst_n)
			shown |-> dec_o[g] == exp_w[g])
			else count_error($sformatf("slot %0d decoded word mismatch", g));
	end

	pc_ok: assert property (@(posedge clk) disable iff (!arst_n) shown |-> dec_pc == base)
		else count_error("dec_pc mismatch");
	// bubbles carry no loop state
	lbd_ok: assert property (@(posedge clk) disable iff (!arst_n)
		lbd_state == (shown ? exp_lbd : 2'd0))
		else count_error("lbd_state mismatch");
	start_ok: assert property (@(posedge clk) disable iff (!arst_n)
		loop_start == (shown && exp_ls))
		else count_error("loop_start mismatch");

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == 2000) begin
			$display("timeout: the run did not finish within 2000 cycles");
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		arst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		redirect_en = 1'b0;
		redirect_pc = '0;
		stall = 1'b1;
		rng = 32'he05c;
		loops = 0;
		groups = 0;
		chk_err = 0;
		other_err = 0;
		cycles = 0;
		for (int i = 0; i < 1024; i++) begin
			cnt_m[i] = '0;
		end
		// filler without branches
		for (int i = 0; i < 256; i++) begin
			fill = next_rand();
			mem_m[i / 4][16*(i % 4) +: 16] = {4'(fill % 32'd6), fill[27:16]};
		end
		mem_m[0] = {16'h4242, 16'h2451, 16'h1448, 16'h3245};
		mem_m[1] = {16'h3603, 16'h0000, 16'h1650, 16'h5863};
		// forward beq at pc 9
		mem_m[2] = {16'h2690, 16'h1448, 16'h6284, 16'h3441};
		// loop at pc 17..19, beq back to 17
		mem_m[4][63:16] = {16'h6a7d, 16'h1690, 16'h3241};
		repeat (4) step();
		arst_n = 1'b1;
		for (int i = 0; i < 64; i++) begin
			imem_we = 1'b1;
			imem_addr = 6'(i);
			imem_wdata = mem_m[i];
			step();
		end
		imem_we = 1'b0;
		stall = 1'b0;
		wait (loops >= 5);
		step();
		redirect_en = 1'b1;
		redirect_pc = 16'd30;
		step();
		redirect_en = 1'b0;
		for (int k = 1; k <= 3; k++) begin
			repeat (3 + int'(next_rand() % 32'd5)) step();
			stall = 1'b1;
			repeat (k) step();
			stall = 1'b0;
		end
		repeat (10) step();
		if (groups < 20) begin
			other_err++;
			$display("too few decoded groups were seen");
		end
		$display("errors: %0d check, %0d other", chk_err, other_err);
		if (chk_err == 0 && other_err == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
source/frontend_pkg.sv
source/fetch_if.sv
source/fetch_unit.sv
source/if_id_reg.sv
source/inst_decoder.sv
source/loop_detector.sv
source/decode_stage.sv
source/frontend_top.sv
dv/frontend_assertions.sv
dv/frontend_tb.sv

/* source/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import frontend_pkg::*; (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             stall,
	fetch_if.dst             in,
	output logic [dec_w-1:0] dec_inst0,
	output logic [dec_w-1:0] dec_inst1,
	output logic [dec_w-1:0] dec_inst2,
	output logic [dec_w-1:0] dec_inst3,
	output logic [pc_w-1:0]  dec_pc,
	output logic [1:0]       lbd_state,
	output logic             loop_start
);

	logic [dec_w-1:0] dec_c [slots];
	logic [dec_w-1:0] dec_q [slots];
	logic br_any;
	logic [slot_iw-1:0] br_idx;
	logic br_valid;
	logic [pc_w-1:0] br_pc;

	for (genvar g = 0; g < slots; g++) begin : g_dec
		inst_decoder u_dec (
			.inst       (in.inst[g*inst_w +: inst_w]),
			.slot_valid (in.valid_mask[g]),
			.pred_taken (in.pred_result[g]),
			.dec        (dec_c[g])
		);
	end

	// first predicted-taken valid slot
	always_comb begin
		br_any = 1'b0;
		br_idx = '0;
		for (int i = slots - 1; i >= 0; i--) begin
			if (in.valid_mask[i] && in.pred_result[i]) begin
				br_any = 1'b1;
				br_idx = slot_iw'(i);
			end
		end
	end

	// held group is seen again after the stall, count it only then
	assign br_valid = br_any && !stall;
	assign br_pc = {in.pc[pc_w-1:slot_iw], br_idx};

	loop_detector u_lbd (
		.clk        (clk),
		.arst_n     (arst_n),
		.br_valid   (br_valid),
		.br_pc      (br_pc),
		.lbd_state  (lbd_state),
		.loop_start (loop_start)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_pc <= '0;
			for (int i = 0; i < slots; i++) begin
				dec_q[i] <= '0;
			end
		end else begin
			dec_pc <= in.pc;
			for (int i = 0; i < slots; i++) begin
				dec_q[i] <= {dec_c[i][dec_w-1] & ~stall, dec_c[i][dec_w-2:0]};
			end
		end
	end

	assign dec_inst0 = dec_q[0];
	assign dec_inst1 = dec_q[1];
	assign dec_inst2 = dec_q[2];
	assign dec_inst3 = dec_q[3];

endmodule

`default_nettype wire

/* source/fetch_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fetch_if import frontend_pkg::*; ();

	logic [pc_w-1:0]    pc;
	logic [group_w-1:0] inst;
	logic [pc_w-1:0]    recv_pc;
	logic [slots-1:0]   pred_result;
	logic [slots-1:0]   valid_mask;

	modport src (
		output pc,
		output inst,
		output recv_pc,
		output pred_result,
		output valid_mask
	);

	modport dst (
		input pc,
		input inst,
		input recv_pc,
		input pred_result,
		input valid_mask
	);

endinterface

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import frontend_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               stall,
	input  logic               redirect_en,
	input  logic [pc_w-1:0]    redirect_pc,
	input  logic               imem_we,
	input  logic [imem_aw-1:0] imem_addr,
	input  logic [group_w-1:0] imem_wdata,
	fetch_if.src               out
);

	logic [group_w-1:0] imem [imem_groups];
	logic [pc_w-1:0] fetch_pc;
	logic [pc_w-1:0] group_pc;
	logic [group_w-1:0] group;
	inst_u slot_u [slots];
	logic [slots-1:0] lead_mask;
	logic [slots-1:0] back_br;
	logic taken;
	logic [slot_iw-1:0] taken_idx;
	logic [pc_w-1:0] after_pc;
	logic [pc_w-1:0] target_pc;
	logic [pc_w-1:0] recv_c;
	logic [pc_w-1:0] next_pc;
	logic [slots-1:0] valid_c;
	logic [slots-1:0] pred_c;

	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	assign group_pc = {fetch_pc[pc_w-1:slot_iw], {slot_iw{1'b0}}};
	assign group = imem[fetch_pc[imem_aw+slot_iw-1:slot_iw]];

	always_comb begin
		for (int i = 0; i < slots; i++) begin
			slot_u[i] = group[i*inst_w +: inst_w];
			lead_mask[i] = (i >= int'(fetch_pc[slot_iw-1:0]));
			back_br[i] = lead_mask[i] && (slot_u[i].i.opcode == op_beq) &&
				slot_u[i].i.imm[imm_w-1];
		end
	end

	// lowest slot wins
	always_comb begin
		taken = 1'b0;
		taken_idx = '0;
		for (int i = slots - 1; i >= 0; i--) begin
			if (back_br[i]) begin
				taken = 1'b1;
				taken_idx = slot_iw'(i);
			end
		end
	end

	assign after_pc = {group_pc[pc_w-1:slot_iw], taken_idx} + 1'b1;
	assign target_pc = after_pc +
		{{(pc_w-imm_w){slot_u[taken_idx].i.imm[imm_w-1]}}, slot_u[taken_idx].i.imm};
	assign recv_c = taken ? after_pc : group_pc + pc_w'(slots);
	assign next_pc = taken ? target_pc : group_pc + pc_w'(slots);

	always_comb begin
		for (int i = 0; i < slots; i++) begin
			valid_c[i] = lead_mask[i] && (!taken || i <= int'(taken_idx));
			pred_c[i] = taken && (i == int'(taken_idx));
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fetch_pc <= '0;
			out.valid_mask <= '0;
			out.pred_result <= '0;
		end else if (redirect_en) begin
			fetch_pc <= redirect_pc;
			out.valid_mask <= '0;
			out.pred_result <= '0;
		end else if (!stall) begin
			fetch_pc <= next_pc;
			out.valid_mask <= valid_c;
			out.pred_result <= pred_c;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			out.pc <= group_pc;
			out.inst <= group;
			out.recv_pc <= recv_c;
		end
	end

endmodule

`default_nettype wire

/* source/frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

	// machine widths
	localparam int pc_w = 16;
	localparam int inst_w = 16;
	localparam int slots = 4;
	localparam int slot_iw = $clog2(slots);
	localparam int group_w = slots * inst_w;

	// instruction memory, one group per word
	localparam int imem_groups = 64;
	localparam int imem_aw = $clog2(imem_groups);

	localparam int lat_entries = 4;
	localparam int lat_iw = $clog2(lat_entries);

	// instruction fields
	localparam int op_w = 4;
	localparam int reg_w = 3;
	localparam int imm_w = 6;
	localparam int cls_w = 3;

	// valid, is_branch, pred_taken, uses_imm, class, rd, rs1, rs2, imm
	localparam int dec_w = 4 + cls_w + 3 * reg_w + imm_w;

	localparam logic [op_w-1:0] op_nop = 4'h0;
	localparam logic [op_w-1:0] op_add = 4'h1;
	localparam logic [op_w-1:0] op_sub = 4'h2;
	localparam logic [op_w-1:0] op_addi = 4'h3;
	localparam logic [op_w-1:0] op_ld = 4'h4;
	localparam logic [op_w-1:0] op_st = 4'h5;
	localparam logic [op_w-1:0] op_beq = 4'h6;

	// opcode classes in the decoded word
	localparam logic [cls_w-1:0] cls_nop = 3'd0;
	localparam logic [cls_w-1:0] cls_add = 3'd1;
	localparam logic [cls_w-1:0] cls_sub = 3'd2;
	localparam logic [cls_w-1:0] cls_ld = 3'd3;
	localparam logic [cls_w-1:0] cls_st = 3'd4;
	localparam logic [cls_w-1:0] cls_br = 3'd5;

	typedef union packed {
		struct packed {
			logic [op_w-1:0]  opcode;
			logic [reg_w-1:0] rd;
			logic [reg_w-1:0] rs1;
			logic [reg_w-1:0] rs2;
			logic [2:0]       funct;
		} r;
		// branch offset counts instructions
		struct packed {
			logic [op_w-1:0]         opcode;
			logic [reg_w-1:0]        rd;
			logic [reg_w-1:0]        rs1;
			logic signed [imm_w-1:0] imm;
		} i;
	} inst_u;

endpackage

`default_nettype wire

/* source/frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top import frontend_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               imem_we,
	input  logic [imem_aw-1:0] imem_addr,
	input  logic [group_w-1:0] imem_wdata,
	input  logic               redirect_en,
	input  logic [pc_w-1:0]    redirect_pc,
	input  logic               stall,
	output logic [dec_w-1:0]   dec_inst0,
	output logic [dec_w-1:0]   dec_inst1,
	output logic [dec_w-1:0]   dec_inst2,
	output logic [dec_w-1:0]   dec_inst3,
	output logic [pc_w-1:0]    dec_pc,
	output logic [1:0]         lbd_state,
	output logic               loop_start
);

	fetch_if fetch_grp ();
	fetch_if id_grp ();

	fetch_unit u_fetch (
		.clk         (clk),
		.arst_n      (arst_n),
		.stall       (stall),
		.redirect_en (redirect_en),
		.redirect_pc (redirect_pc),
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_wdata  (imem_wdata),
		.out         (fetch_grp)
	);

	// a redirect also drops the group already in IF/ID
	if_id_reg u_if_id (
		.clk    (clk),
		.arst_n (arst_n),
		.stall  (stall),
		.flush  (redirect_en),
		.in     (fetch_grp),
		.out    (id_grp)
	);

	decode_stage u_decode (
		.clk        (clk),
		.arst_n     (arst_n),
		.stall      (stall),
		.in         (id_grp),
		.dec_inst0  (dec_inst0),
		.dec_inst1  (dec_inst1),
		.dec_inst2  (dec_inst2),
		.dec_inst3  (dec_inst3),
		.dec_pc     (dec_pc),
		.lbd_state  (lbd_state),
		.loop_start (loop_start)
	);

endmodule

`default_nettype wire

/* source/if_id_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module if_id_reg (
	input  logic clk,
	input  logic arst_n,
	input  logic stall,
	input  logic flush,
	fetch_if.dst in,
	fetch_if.src out
);

	// flush beats stall
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out.valid_mask <= '0;
			out.pred_result <= '0;
		end else if (flush) begin
			out.valid_mask <= '0;
			out.pred_result <= '0;
		end else if (!stall) begin
			out.valid_mask <= in.valid_mask;
			out.pred_result <= in.pred_result;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			out.pc <= in.pc;
			out.inst <= in.inst;
			out.recv_pc <= in.recv_pc;
		end
	end

endmodule

`default_nettype wire

/* source/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import frontend_pkg::*; (
	input  logic [inst_w-1:0] inst,
	input  logic              slot_valid,
	input  logic              pred_taken,
	output logic [dec_w-1:0]  dec
);

	inst_u u;
	logic known;
	logic is_branch;
	logic uses_imm;
	logic [cls_w-1:0] cls;
	logic [reg_w-1:0] rd;
	logic [reg_w-1:0] rs1;
	logic [reg_w-1:0] rs2;
	logic [imm_w-1:0] imm;

	assign u = inst;

	always_comb begin
		known = 1'b1;
		is_branch = 1'b0;
		uses_imm = 1'b0;
		cls = cls_nop;
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		imm = '0;
		case (u.r.opcode)
			op_nop: begin
				cls = cls_nop;
			end
			op_add, op_sub: begin
				cls = (u.r.opcode == op_add) ? cls_add : cls_sub;
				rd = u.r.rd;
				rs1 = u.r.rs1;
				rs2 = u.r.rs2;
			end
			op_addi, op_ld: begin
				cls = (u.i.opcode == op_addi) ? cls_add : cls_ld;
				uses_imm = 1'b1;
				rd = u.i.rd;
				rs1 = u.i.rs1;
				imm = u.i.imm;
			end
			// store data and second compare operand sit in the rd field
			op_st, op_beq: begin
				cls = (u.i.opcode == op_st) ? cls_st : cls_br;
				is_branch = (u.i.opcode == op_beq);
				uses_imm = 1'b1;
				rs1 = u.i.rs1;
				rs2 = u.i.rd;
				imm = u.i.imm;
			end
			default: begin
				known = 1'b0;
			end
		endcase
		if (!slot_valid || !known) begin
			dec = '0;
		end else begin
			dec = {1'b1, is_branch, pred_taken, uses_imm, cls, rd, rs1, rs2, imm};
		end
	end

endmodule

`default_nettype wire

/* source/loop_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module loop_detector import frontend_pkg::*; (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            br_valid,
	input  logic [pc_w-1:0] br_pc,
	output logic [1:0]      lbd_state,
	output logic            loop_start
);

	logic [pc_w-1:0] lat_pc [lat_entries];
	logic [1:0] lat_cnt [lat_entries];
	logic [lat_entries-1:0] lat_vld;
	logic [lat_iw-1:0] rr_ptr;
	logic hit;
	logic [lat_iw-1:0] hit_idx;
	logic [1:0] new_cnt;

	// associative lookup
	always_comb begin
		hit = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < lat_entries; i++) begin
			if (lat_vld[i] && (lat_pc[i] == br_pc)) begin
				hit = 1'b1;
				hit_idx = lat_iw'(i);
			end
		end
	end

	// saturates at 3
	always_comb begin
		if (!hit) begin
			new_cnt = 2'd1;
		end else if (lat_cnt[hit_idx] == 2'd3) begin
			new_cnt = 2'd3;
		end else begin
			new_cnt = lat_cnt[hit_idx] + 2'd1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lat_vld <= '0;
			rr_ptr <= '0;
			lbd_state <= '0;
			loop_start <= 1'b0;
			for (int i = 0; i < lat_entries; i++) begin
				lat_cnt[i] <= '0;
			end
		end else begin
			lbd_state <= br_valid ? new_cnt : 2'd0;
			loop_start <= br_valid && hit && (lat_cnt[hit_idx] == 2'd2);
			if (br_valid && hit) begin
				lat_cnt[hit_idx] <= new_cnt;
			end else if (br_valid) begin
				lat_vld[rr_ptr] <= 1'b1;
				lat_cnt[rr_ptr] <= 2'd1;
				rr_ptr <= rr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (br_valid && !hit) begin
			lat_pc[rr_ptr] <= br_pc;
		end
	end

endmodule

`default_nettype wire
